// File: verification/uart_vectors.txt
# op  arg  expected: wr = TX write (frame byte or none), rd = read at address,
# tx = serial byte into uart_rx, cts = expected uart_cts level, drain = wait frames
cts   00  00
rd    03  00
wr    5a  none
drain 00  none
wr    c1  41
rd    02  80
wr    55  none
drain 00  none
rd    02  00
wr    7e  7e
drain 00  none
tx    a5  none
cts   00  01
rd    01  80
rd    00  a5
rd    01  00
cts   00  00
tx    33  none
tx    4c  none
rd    00  b3
rd    01  00
cts   00  00
rd    03  00

// File: sources.f
src/uart_line_pkg.sv
src/uart_bus_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_top.sv
verification/tb_clock.sv
verification/uart_assertions.sv
verification/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = uart_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/uart_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the serial port. Runs from the project root, since the
// vector file path is relative to it. Bit time is 16 clocks at these
// parameters and the line model samples uart_tx at mid-bit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_tb;
    import uart_bus_pkg::*;

    localparam int unsigned CLK_HZ     = 250_000_000;
    localparam int unsigned BAUD       = 15_625_000;
    localparam int unsigned OVERSAMPLE = 4;
    // 250 MHz over 15.625 Mbaud
    localparam int BIT_CLKS      = 16;
    localparam int FRAME_TIMEOUT = 24 * BIT_CLKS;

    logic       clk;
    logic       rst;
    cpu_req_t   req;
    logic [7:0] dout;
    logic       serial_in;
    logic       serial_out;
    logic       cts;

    // frames the line model still has to see, oldest first
    logic [7:0] exp_frames[$];
    int         value_errs;
    int         other_errs;
    int         vec_count;

    tb_clock #(.PERIOD_NS(4)) u_clock (.clk(clk));

    uart_top #(
        .CLK_HZ     (CLK_HZ),
        .BAUD       (BAUD),
        .OVERSAMPLE (OVERSAMPLE)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .dout     (dout),
        .uart_rx  (serial_in),
        .uart_tx  (serial_out),
        .uart_cts (cts)
    );

    task automatic drive_idle();
        req.enable  = 1'b0;
        req.w_en    = 1'b0;
        req.address = ADDR_RX;
        req.din     = 8'h00;
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = 2 + ($urandom % 4);
        repeat (gap) @(posedge clk);
    endtask

    task automatic cpu_write(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        req.enable  = 1'b1;
        req.w_en    = 1'b1;
        req.address = addr;
        req.din     = data;
        @(posedge clk);
        #1;
        drive_idle();
    endtask

    // dout holds the selected value one cycle after the address
    task automatic cpu_read(input logic [1:0] addr, output logic [7:0] data);
        @(posedge clk);
        #1;
        req.enable  = 1'b1;
        req.w_en    = 1'b0;
        req.address = addr;
        req.din     = 8'h00;
        @(posedge clk);
        #1;
        data = dout;
        req.enable = 1'b0;
    endtask

    // 8N1 frame into uart_rx, cts is checked in the middle of the frame
    task automatic serial_send(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            #1;
            serial_in = frame[i];
            if (i == 4)
            begin
                @(negedge clk);
                assert (cts == 1'b1)
                else
                begin
                    value_errs++;
                    $display("FAILED %0t ns: uart_cts low while a frame is received", $time);
                end
            end
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic drain_frames();
        int waited;
        waited = 0;
        while (exp_frames.size() != 0 && waited < FRAME_TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        assert (exp_frames.size() == 0)
        else
        begin
            other_errs++;
            $display("timeout: %0d expected frame(s) never appeared on uart_tx",
                     exp_frames.size());
            exp_frames.delete();
        end
        // long enough for a stray frame to be decoded
        repeat (12 * BIT_CLKS) @(posedge clk);
    endtask

    task automatic run_vector(input string line);
        string      op;
        string      exp_s;
        logic [7:0] arg;
        logic [7:0] exp_v;
        logic [7:0] got;
        int         n;
        n = $sscanf(line, "%s %h %s", op, arg, exp_s);
        if (n != 3)
        begin
            other_errs++;
            $display("malformed vector line: %s", line);
            return;
        end
        exp_v = 8'h00;
        if (exp_s != "none")
            void'($sscanf(exp_s, "%h", exp_v));
        vec_count++;
        if (op == "wr")
        begin
            cpu_write(ADDR_TX, arg);
            if (exp_s != "none")
                exp_frames.push_back(exp_v);
        end
        else if (op == "rd")
        begin
            cpu_read(arg[1:0], got);
            assert (got == exp_v)
            else
            begin
                value_errs++;
                $display("FAILED %0t ns: read at address %0d gave %02h, expected %02h",
                         $time, arg[1:0], got, exp_v);
            end
        end
        else if (op == "tx")
            serial_send(arg);
        else if (op == "cts")
        begin
            @(negedge clk);
            assert (cts == exp_v[0])
            else
            begin
                value_errs++;
                $display("FAILED %0t ns: uart_cts is %0b, expected %0b",
                         $time, cts, exp_v[0]);
            end
        end
        else if (op == "drain")
            drain_frames();
        else
        begin
            other_errs++;
            $display("unknown operation in vector file: %s", op);
        end
        idle_gap();
    endtask

    // line model, decodes every frame on uart_tx at mid-bit
    initial
    begin : line_model
        logic [7:0] got;
        logic       stop_bit;
        logic       start_ok;
        forever
        begin
            @(negedge clk);
            if (!rst && serial_out === 1'b0)
            begin
                repeat (BIT_CLKS / 2) @(negedge clk);
                start_ok = (serial_out == 1'b0);
                for (int i = 0; i < 8; i++)
                begin
                    repeat (BIT_CLKS) @(negedge clk);
                    got[i] = serial_out;
                end
                repeat (BIT_CLKS) @(negedge clk);
                stop_bit = serial_out;
                if (!start_ok)
                begin
                    other_errs++;
                    $display("start bit on uart_tx did not last to its middle");
                end
                else if (exp_frames.size() == 0)
                begin
                    other_errs++;
                    $display("unexpected frame %02h on uart_tx at %0t ns", got, $time);
                end
                else
                begin
                    assert (got == exp_frames[0])
                    else
                    begin
                        value_errs++;
                        $display("FAILED %0t ns: frame data %02h, expected %02h",
                                 $time, got, exp_frames[0]);
                    end
                    void'(exp_frames.pop_front());
                end
                assert (stop_bit == 1'b1)
                else
                begin
                    value_errs++;
                    $display("FAILED %0t ns: stop bit on uart_tx is low", $time);
                end
            end
        end
    end

    initial
    begin : main
        int    fd;
        int    n;
        string line;
        value_errs = 0;
        other_errs = 0;
        vec_count  = 0;
        void'($urandom(32'h0821_12ae));
        rst       = 1'b1;
        serial_in = 1'b1;
        drive_idle();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("verification/uart_vectors.txt", "r");
        if (fd == 0)
        begin
            other_errs++;
            $display("could not open verification/uart_vectors.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#")
                    run_vector(line);
            end
            $fclose(fd);
        end

        assert (exp_frames.size() == 0)
        else
        begin
            other_errs++;
            $display("%0d expected frame(s) left unseen at the end", exp_frames.size());
        end

        $display("vectors %0d, value errors %0d, other errors %0d",
                 vec_count, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verification/uart_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks on the register block, bound into every uart_regs.
// Checks are off while rst is high.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_assertions (
    input logic                   clk,
    input logic                   rst,
    input uart_bus_pkg::cpu_req_t req,
    input logic                   tx_start,
    input logic                   tx_busy,
    input logic                   rx_valid,
    input logic                   ack,
    input logic                   cts
);
    import uart_bus_pkg::*;

    logic rx_read;
    logic waiting_q;

    assign rx_read = req.enable && !req.w_en && (req.address == ADDR_RX);

    // a byte waits from its valid strobe until the cycle after the acknowledge
    // a byte that lands on a waiting one is dropped
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            waiting_q <= 1'b0;
        else if (rx_valid && !waiting_q)
            waiting_q <= 1'b1;
        else if (ack)
            waiting_q <= 1'b0;
    end

    strobe_when_idle: assert property (@(posedge clk) disable iff (rst)
        !(tx_start && tx_busy))
        else $error("tx start strobe high while the transmitter is busy");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(rx_read) && !$past(ack))
        else $error("receive acknowledge not a single cycle after an RX read");

    // a waiting byte must hold the far end off
    cts_when_held: assert property (@(posedge clk) disable iff (rst)
        waiting_q |-> cts)
        else $error("cts low while a received byte is waiting");

endmodule

bind uart_regs uart_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .tx_start (tx_cmd.start),
    .tx_busy  (tx_busy),
    .rx_valid (rx.valid),
    .ack      (ack_q),
    .cts      (cts)
);

// File: verification/tb_clock.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free running testbench clock, starts low. PERIOD_NS should be even.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: src/uart_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial port top level. Fixed 8N1 framing, no parity, FIFO or interrupt.
// The CPU request is sampled every clock whether enable is set or not.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_top #(
    parameter int unsigned CLK_HZ     = uart_line_pkg::DEFAULT_CLK_HZ,
    parameter int unsigned BAUD       = uart_line_pkg::DEFAULT_BAUD,
    parameter int unsigned OVERSAMPLE = uart_line_pkg::DEFAULT_OVERSAMPLE
) (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_bus_pkg::cpu_req_t req,
    output logic [7:0]             dout,
    input  logic                   uart_rx,
    output logic                   uart_tx,
    output logic                   uart_cts
);
    import uart_bus_pkg::*;

    tx_cmd_t  tx_cmd;
    logic     tx_busy;
    rx_byte_t rx_byte;
    logic     rx_idle;

    uart_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .dout    (dout),
        .tx_cmd  (tx_cmd),
        .tx_busy (tx_busy),
        .rx      (rx_byte),
        .rx_idle (rx_idle),
        .cts     (uart_cts)
    );

    uart_tx #(
        .CLK_HZ (CLK_HZ),
        .BAUD   (BAUD)
    ) u_tx (
        .clk  (clk),
        .rst  (rst),
        .cmd  (tx_cmd),
        .txd  (uart_tx),
        .busy (tx_busy)
    );

    uart_rx #(
        .CLK_HZ     (CLK_HZ),
        .BAUD       (BAUD),
        .OVERSAMPLE (OVERSAMPLE)
    ) u_rx (
        .clk  (clk),
        .rst  (rst),
        .rxd  (uart_rx),
        .rx   (rx_byte),
        .idle (rx_idle)
    );

endmodule

// File: src/uart_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU register block. The first transmit write after reset is dropped
// since the monitor sends a port set-up byte there. A received byte is
// dropped while the previous one is unread. Reads return 7 bit data.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_bus_pkg::cpu_req_t req,
    output logic [7:0]             dout,
    output uart_bus_pkg::tx_cmd_t  tx_cmd,
    input  logic                   tx_busy,
    input  uart_bus_pkg::rx_byte_t rx,
    input  logic                   rx_idle,
    output logic                   cts
);
    import uart_bus_pkg::*;

    logic       held_q;
    logic [6:0] held_data_q;
    logic       ack_q;
    logic       skip_done_q;
    logic       tx_start_q;
    logic [6:0] tx_data_q;
    logic [7:0] dout_q;
    logic       tx_write;
    logic       rx_read;
    logic       take_rx;

    assign tx_write = req.enable && req.w_en && (req.address == ADDR_TX);
    assign rx_read  = req.enable && !req.w_en && (req.address == ADDR_RX);
    assign take_rx  = rx.valid && !held_q;

    // holding flag, set by the receiver and cleared by the CPU read
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            held_q <= 1'b0;
        else if (take_rx)
            held_q <= 1'b1;
        else if (ack_q)
            held_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (take_rx)
            held_data_q <= rx.data[6:0];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ack_q       <= 1'b0;
            skip_done_q <= 1'b0;
            tx_start_q  <= 1'b0;
            dout_q      <= 8'd0;
        end
        else
        begin
            tx_start_q <= 1'b0;
            // one cycle pulse even when the CPU holds the address
            ack_q <= rx_read && !ack_q;

            // busy only rises the cycle after the strobe, so block a second strobe too
            if (tx_write)
            begin
                if (!skip_done_q)
                    skip_done_q <= 1'b1;
                else if (!tx_busy && !tx_start_q)
                    tx_start_q <= 1'b1;
            end

            case (req.address)
            ADDR_RX:   dout_q <= {held_q, held_data_q};
            ADDR_RXCR: dout_q <= {held_q, 7'd0};
            ADDR_TX:   dout_q <= {tx_busy, 7'd0};
            default:   dout_q <= 8'd0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_write && skip_done_q && !tx_busy && !tx_start_q)
            tx_data_q <= req.din[6:0];
    end

    // terminal side only carries 7 bits
    assign tx_cmd.start = tx_start_q;
    assign tx_cmd.data  = {1'b0, tx_data_q};

    assign dout = dout_q;
    assign cts  = !rx_idle || held_q;

endmodule

// File: src/uart_rx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Oversampling 8N1 receiver. OVERSAMPLE must be 2 or more and the bit time
// at least OVERSAMPLE clocks. A frame with a low stop bit is discarded.
// valid lands in the stop bit, its exact cycle depends on the tick phase.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_rx #(
    parameter int unsigned CLK_HZ     = uart_line_pkg::DEFAULT_CLK_HZ,
    parameter int unsigned BAUD       = uart_line_pkg::DEFAULT_BAUD,
    parameter int unsigned OVERSAMPLE = uart_line_pkg::DEFAULT_OVERSAMPLE
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rxd,
    output uart_bus_pkg::rx_byte_t rx,
    output logic                   idle
);
    import uart_line_pkg::*;

    localparam int unsigned TPS = ticks_per_sample(CLK_HZ, BAUD, OVERSAMPLE);
    localparam int TICK_W = (TPS > 1) ? $clog2(TPS) : 1;
    localparam int OS_W = $clog2(OVERSAMPLE);
    localparam logic [OS_W-1:0] OS_HALF = OS_W'(OVERSAMPLE / 2 - 1);
    localparam logic [OS_W-1:0] OS_LAST = OS_W'(OVERSAMPLE - 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t            state_q;
    logic [1:0]        sync_q;
    logic              rxd_s;
    logic [TICK_W-1:0] tick_cnt_q;
    logic              tick;
    logic [OS_W-1:0]   os_cnt_q;
    logic [2:0]        bit_cnt_q;
    logic [7:0]        shift_q;
    logic              valid_q;
    logic              sample_data;

    // two flop synchroniser, line idles high
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sync_q <= 2'b11;
        else
            sync_q <= {sync_q[0], rxd};
    end

    assign rxd_s = sync_q[1];

    // free running sample tick
    assign tick = (tick_cnt_q == TICK_W'(TPS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            tick_cnt_q <= '0;
        else if (tick)
            tick_cnt_q <= '0;
        else
            tick_cnt_q <= tick_cnt_q + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state_q   <= S_IDLE;
            os_cnt_q  <= '0;
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            if (tick)
            begin
                case (state_q)
                S_IDLE:
                begin
                    os_cnt_q <= '0;
                    if (!rxd_s)
                        state_q <= S_START;
                end
                S_START:
                begin
                    // half a bit after the edge, a high line was only a glitch
                    if (os_cnt_q == OS_HALF)
                    begin
                        os_cnt_q  <= '0;
                        bit_cnt_q <= '0;
                        state_q   <= rxd_s ? S_IDLE : S_DATA;
                    end
                    else
                        os_cnt_q <= os_cnt_q + 1'b1;
                end
                S_DATA:
                begin
                    if (os_cnt_q == OS_LAST)
                    begin
                        os_cnt_q  <= '0;
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7)
                            state_q <= S_STOP;
                    end
                    else
                        os_cnt_q <= os_cnt_q + 1'b1;
                end
                default:
                begin
                    // middle of the stop bit
                    if (os_cnt_q == OS_LAST)
                    begin
                        os_cnt_q <= '0;
                        valid_q  <= rxd_s;
                        state_q  <= S_IDLE;
                    end
                    else
                        os_cnt_q <= os_cnt_q + 1'b1;
                end
                endcase
            end
        end
    end

    assign sample_data = tick && (state_q == S_DATA) && (os_cnt_q == OS_LAST);

    // LSB arrives first
    always_ff @(posedge clk)
    begin
        if (sample_data)
            shift_q <= {rxd_s, shift_q[7:1]};
    end

    assign rx.valid = valid_q;
    assign rx.data  = shift_q;
    assign idle     = (state_q == S_IDLE);

endmodule

// File: src/uart_tx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 transmitter. A start strobe seen while busy is low is ignored
// otherwise. busy rises the cycle after the strobe and falls when the stop
// bit ends. CLK_HZ must be at least BAUD.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_tx #(
    parameter int unsigned CLK_HZ = uart_line_pkg::DEFAULT_CLK_HZ,
    parameter int unsigned BAUD   = uart_line_pkg::DEFAULT_BAUD
) (
    input  logic                  clk,
    input  logic                  rst,
    input  uart_bus_pkg::tx_cmd_t cmd,
    output logic                  txd,
    output logic                  busy
);
    import uart_line_pkg::*;

    localparam int unsigned CPB = clks_per_bit(CLK_HZ, BAUD);
    localparam int CNT_W = (CPB > 1) ? $clog2(CPB) : 1;

    logic [CNT_W-1:0] baud_cnt_q;
    logic [3:0]       bit_cnt_q;
    logic [8:0]       shift_q;
    logic             txd_q;
    logic             busy_q;
    logic             bit_end;

    // last cycle of the current bit time
    assign bit_end = (baud_cnt_q == CNT_W'(CPB - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy_q     <= 1'b0;
            txd_q      <= 1'b1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end
        else if (!busy_q)
        begin
            // start bit goes out on the same edge that takes the strobe
            if (cmd.start)
            begin
                busy_q     <= 1'b1;
                txd_q      <= 1'b0;
                baud_cnt_q <= '0;
                bit_cnt_q  <= '0;
            end
        end
        else if (bit_end)
        begin
            baud_cnt_q <= '0;
            // bit 9 is the stop bit, line is already high
            if (bit_cnt_q == 4'd9)
            begin
                busy_q <= 1'b0;
            end
            else
            begin
                txd_q     <= shift_q[0];
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end
        else
        begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
        end
    end

    // data bits LSB first, a one behind them becomes the stop bit
    always_ff @(posedge clk)
    begin
        if (!busy_q && cmd.start)
            shift_q <= {1'b1, cmd.data};
        else if (busy_q && bit_end)
            shift_q <= {1'b1, shift_q[8:1]};
    end

    assign txd  = txd_q;
    assign busy = busy_q;

endmodule

// File: src/uart_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU side register map and the strobes between the register block and
// the serial engines. Only three addresses are decoded, address 3 reads 0.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_bus_pkg;

    // register addresses
    localparam logic [1:0] ADDR_RX   = 2'd0;
    localparam logic [1:0] ADDR_RXCR = 2'd1;
    localparam logic [1:0] ADDR_TX   = 2'd2;

    // one CPU cycle, driven every clock
    typedef struct packed {
        logic       enable;
        logic [1:0] address;
        logic       w_en;
        logic [7:0] din;
    } cpu_req_t;

    // start strobe is one cycle wide and only sent while the transmitter is idle
    typedef struct packed {
        logic       start;
        logic [7:0] data;
    } tx_cmd_t;

    // valid pulses for one cycle, data holds until the next frame shifts in
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

endpackage

// File: src/uart_line_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial line timing. The bit period is the clock rate over the baud rate,
// truncated, so a baud rate that does not divide the clock drifts a little.
// The sample tick is the bit period over the oversampling factor.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_line_pkg;

    // defaults for the top level, 25 MHz core clock
    localparam int unsigned DEFAULT_CLK_HZ     = 25_000_000;
    localparam int unsigned DEFAULT_BAUD       = 115_200;
    localparam int unsigned DEFAULT_OVERSAMPLE = 8;

    // clock cycles in one bit time
    function automatic int unsigned clks_per_bit(input int unsigned clk_hz,
                                                 input int unsigned baud);
        return clk_hz / baud;
    endfunction

    // clock cycles between receiver sample ticks
    function automatic int unsigned ticks_per_sample(input int unsigned clk_hz,
                                                     input int unsigned baud,
                                                     input int unsigned oversample);
        return clks_per_bit(clk_hz, baud) / oversample;
    endfunction

endpackage
